//--- mpca.f
src/mpca_pkg.sv
src/packet_decrypt.sv
src/priority_score.sv
src/rank_sort.sv
src/channel_alloc.sv
src/mpca.sv
tests/mpca_sva.sv
tests/mpca_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds and runs the mpca testbench; exit status is the simulator's
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module mpca_tb -f mpca.f -o mpca_sim \
    && ./obj_dir/mpca_sim \
    || exit 1

//--- src/channel_alloc.sv
`default_nettype none

module channel_alloc (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     stage_valid,
    input  wire mpca_pkg::req_vec_t req,
    input  wire mpca_pkg::rank_t    rank,
    input  wire mpca_pkg::cap_t     cap,
    output mpca_pkg::grant_t        grant_channel,
    output logic                    out_valid
);

    import mpca_pkg::*;

    // next channel, modulo 3
    function automatic ch_t next_ch(input ch_t c);
        return (c == ch_t'(NUM_CH - 1)) ? 2'd0 : c + 2'd1;
    endfunction

    cap_t       caps;
    grant_t     grant;
    ch_t        pivot;
    ch_t        pref;
    ch_t        cand;
    ch_t        pick;
    logic [2:0] idx;

    // ==================================================================
    // walk the ranks, capacities and pivot carried along
    // ==================================================================

    always_comb begin
        caps  = cap;
        grant = {NUM_REQ{NO_GRANT}};
        pref  = req[rank[0]].u.prefer;
        pivot = (pref == NO_GRANT) ? 2'd0 : pref;
        cand  = 2'd0;
        pick  = NO_GRANT;
        idx   = '0;

        for (int k = 0; k < NUM_REQ; k++) begin
            idx  = rank[k];
            pref = req[idx].u.prefer;
            pick = NO_GRANT;
            cand = pivot;

            if (req[idx].u.valid) begin
                if (pref != NO_GRANT && caps[pref] != 3'd0) begin
                    pick = pref;
                end else begin
                    // fallback pivot, pivot+1, pivot+2
                    for (int t = 0; t < NUM_CH; t++) begin
                        if (pick == NO_GRANT && caps[cand] != 3'd0) begin
                            pick = cand;
                        end
                        cand = next_ch(cand);
                    end
                end
            end

            if (pick != NO_GRANT) begin
                caps[pick] = caps[pick] - 3'd1;
                grant[idx] = pick;
                pivot      = next_ch(pivot);
            end else begin
                pivot = next_ch(next_ch(pivot));
            end
        end
    end

    // stage 2 register, grants hold between items
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid     <= 1'b0;
            grant_channel <= {NUM_REQ{NO_GRANT}};
        end else begin
            out_valid <= stage_valid;
            if (stage_valid) begin
                grant_channel <= grant;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/mpca.sv
`default_nettype none

module mpca (
    input  wire                                            clk,
    input  wire                                            reset,
    input  wire                                            in_valid,
    input  wire mpca_pkg::block_t [mpca_pkg::NUM_BLK-1:0]  packets,
    input  wire mpca_pkg::key_t                            key,
    input  wire mpca_pkg::cap_t                            channel_capacity,
    output logic                                           out_valid,
    output mpca_pkg::grant_t                               grant_channel
);

    import mpca_pkg::*;

    // stage 1 outputs
    req_vec_t req_s1;
    cap_t     cap_s1;
    logic     valid_s1;

    // stage 2 combinational path
    score_t [NUM_REQ-1:0] score;
    rank_t                rank;

    packet_decrypt u_decrypt (
        .clk              (clk),
        .reset            (reset),
        .in_valid         (in_valid),
        .packets          (packets),
        .key              (key),
        .channel_capacity (channel_capacity),
        .req              (req_s1),
        .cap              (cap_s1),
        .req_valid        (valid_s1)
    );

    priority_score u_score (
        .req   (req_s1),
        .score (score)
    );

    rank_sort u_sort (
        .req   (req_s1),
        .score (score),
        .rank  (rank)
    );

    channel_alloc u_alloc (
        .clk           (clk),
        .reset         (reset),
        .stage_valid   (valid_s1),
        .req           (req_s1),
        .rank          (rank),
        .cap           (cap_s1),
        .grant_channel (grant_channel),
        .out_valid     (out_valid)
    );

endmodule

`default_nettype wire

//--- src/mpca_pkg.sv
`default_nettype none

package mpca_pkg;

    // ==================================================================
    // sizes
    // ==================================================================

    localparam int NUM_REQ = 8;
    localparam int NUM_BLK = 4;
    localparam int NUM_CH  = 3;
    localparam int ROUNDS  = 4;

    // cipher half-word and one encrypted block
    typedef logic [15:0] word_t;

    typedef struct packed {
        word_t y;
        word_t x;
    } block_t;

    // four round keys come out of this
    typedef logic [ROUNDS*$bits(word_t)-1:0] key_t;

    // channel 0 sits in the low bits
    typedef logic [NUM_CH-1:0][2:0] cap_t;

    typedef logic [1:0] ch_t;
    localparam ch_t NO_GRANT = 2'd3;

    typedef ch_t [NUM_REQ-1:0] grant_t;

    // wraps at 6 bits signed
    typedef logic signed [5:0] score_t;

    // ==================================================================
    // request word, two readings of the same 16 bits
    // ==================================================================

    typedef struct packed {
        logic       valid;
        logic [1:0] qos;
        logic [3:0] len;
        logic [1:0] congestion;
        logic [1:0] prefer;
        logic [2:0] src_hint;
        logic       mode;
        logic       spare;
    } req_u_t;

    // mode = 1 view
    typedef struct packed {
        logic              valid;
        logic signed [1:0] qos;
        logic signed [3:0] len;
        logic signed [1:0] congestion;
        logic        [1:0] prefer;
        logic signed [2:0] src_hint;
        logic              mode;
        logic              spare;
    } req_s_t;

    typedef union packed {
        req_u_t u;
        req_s_t s;
    } req_t;

    typedef req_t [NUM_REQ-1:0] req_vec_t;

    // rank position 0 holds the index of the winner
    typedef logic [NUM_REQ-1:0][2:0] rank_t;

endpackage

`default_nettype wire

//--- src/packet_decrypt.sv
`default_nettype none

module packet_decrypt (
    input  wire                                        clk,
    input  wire                                        reset,
    input  wire                                        in_valid,
    input  wire mpca_pkg::block_t [mpca_pkg::NUM_BLK-1:0] packets,
    input  wire mpca_pkg::key_t                        key,
    input  wire mpca_pkg::cap_t                        channel_capacity,
    output mpca_pkg::req_vec_t                         req,
    output mpca_pkg::cap_t                             cap,
    output logic                                       req_valid
);

    import mpca_pkg::*;

    localparam int W = $bits(word_t);

    function automatic word_t ror(input word_t v, input int unsigned n);
        return (v >> n) | (v << (W - n));
    endfunction

    function automatic word_t rol(input word_t v, input int unsigned n);
        return (v << n) | (v >> (W - n));
    endfunction

    word_t [ROUNDS-1:0] ksched;
    req_vec_t           dec;

    // ==================================================================
    // key schedule
    // ==================================================================

    always_comb begin
        ksched[0] = key[W-1:0];
        for (int j = 1; j < ROUNDS; j++) begin
            ksched[j] = (ror(ksched[j-1], 7) + key[W*j +: W]) ^ word_t'(j - 1);
        end
    end

    // ==================================================================
    // inverse rounds, last key first
    // ==================================================================

    for (genvar b = 0; b < NUM_BLK; b++) begin : g_blk
        block_t blk;

        always_comb begin
            blk = packets[b];
            for (int r = 0; r < ROUNDS; r++) begin
                blk.y = ror(blk.y ^ blk.x, 2);
                blk.x = rol((blk.x ^ ksched[ROUNDS-1-r]) - blk.y, 9);
            end
        end

        // x feeds the even request, y the odd one
        assign dec[2*b]   = blk.x;
        assign dec[2*b+1] = blk.y;
    end

    // stage 1 register
    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        req <= dec;
        cap <= channel_capacity;
    end

endmodule

`default_nettype wire

//--- src/priority_score.sv
`default_nettype none

module priority_score (
    input  wire mpca_pkg::req_vec_t                   req,
    output mpca_pkg::score_t [mpca_pkg::NUM_REQ-1:0]  score
);

    import mpca_pkg::*;

    // fields widened to score width
    score_t qos;
    score_t len;
    score_t cong;
    score_t hint;

    always_comb begin
        qos  = '0;
        len  = '0;
        cong = '0;
        hint = '0;
        for (int i = 0; i < NUM_REQ; i++) begin
            if (req[i].u.mode) begin
                // signed view sign-extends the fields
                qos  = score_t'(req[i].s.qos);
                len  = score_t'(req[i].s.len);
                cong = score_t'(req[i].s.congestion);
                hint = score_t'(req[i].s.src_hint);
            end else begin
                qos  = score_t'(req[i].u.qos);
                len  = score_t'(req[i].u.len);
                cong = score_t'(req[i].u.congestion);
                hint = score_t'(req[i].u.src_hint);
            end

            // 4q - 2l - 3c + h + 7
            score[i] = (qos <<< 2)
                     - (len <<< 1)
                     - ((cong <<< 1) + cong)
                     + hint
                     + 6'sd7;
        end
    end

endmodule

`default_nettype wire

//--- src/rank_sort.sv
`default_nettype none

module rank_sort (
    input  wire mpca_pkg::req_vec_t                        req,
    input  wire mpca_pkg::score_t [mpca_pkg::NUM_REQ-1:0]  score,
    output mpca_pkg::rank_t                                rank
);

    import mpca_pkg::*;

    // ==================================================================
    // comparator list, six layers of disjoint pairs
    // ==================================================================

    localparam int NUM_CMP = 19;

    localparam logic [0:NUM_CMP-1][2:0] CMP_LO = {
        3'd0, 3'd1, 3'd4, 3'd5,
        3'd0, 3'd1, 3'd2, 3'd3,
        3'd0, 3'd2, 3'd4, 3'd6,
        3'd2, 3'd3,
        3'd1, 3'd3,
        3'd1, 3'd3, 3'd5
    };

    localparam logic [0:NUM_CMP-1][2:0] CMP_HI = {
        3'd2, 3'd3, 3'd6, 3'd7,
        3'd4, 3'd5, 3'd6, 3'd7,
        3'd1, 3'd3, 3'd5, 3'd7,
        3'd4, 3'd5,
        3'd4, 3'd6,
        3'd2, 3'd4, 3'd6
    };

    // true when request b must be ranked ahead of request a
    function automatic logic b_first(
        input logic [2:0]               a,
        input logic [2:0]               b,
        input req_vec_t                 rq,
        input score_t [NUM_REQ-1:0]     sc
    );
        score_t sa;
        score_t sb;
        sa = sc[a];
        sb = sc[b];
        if (rq[a].u.valid != rq[b].u.valid) begin
            return rq[b].u.valid;
        end
        if (sa != sb) begin
            return sb > sa;
        end
        return a > b;
    endfunction

    rank_t      net;
    logic [2:0] ia;
    logic [2:0] ib;

    always_comb begin
        ia = '0;
        ib = '0;
        for (int i = 0; i < NUM_REQ; i++) begin
            net[i] = 3'(i);
        end

        // layers are disjoint, so applying pairs in list order is exact
        for (int c = 0; c < NUM_CMP; c++) begin
            ia = net[CMP_LO[c]];
            ib = net[CMP_HI[c]];
            if (b_first(ia, ib, req, score)) begin
                net[CMP_LO[c]] = ib;
                net[CMP_HI[c]] = ia;
            end
        end
    end

    assign rank = net;

endmodule

`default_nettype wire

//--- tests/mpca_sva.sv
`default_nettype none

module mpca_sva (
    input wire                     clk,
    input wire                     reset,
    input wire                     in_valid,
    input wire mpca_pkg::cap_t     channel_capacity,
    input wire                     out_valid,
    input wire mpca_pkg::grant_t   grant_channel,
    input wire mpca_pkg::req_vec_t req_s1
);

    import mpca_pkg::*;

    logic               seen_in;
    cap_t               cap_d1;
    cap_t               cap_d2;
    logic [NUM_REQ-1:0] valid_d;

    always_ff @(posedge clk) begin
        if (reset) begin
            seen_in <= 1'b0;
        end else if (in_valid) begin
            seen_in <= 1'b1;
        end
    end

    // capacity queue, one entry per pipeline stage
    always_ff @(posedge clk) begin
        cap_d1 <= channel_capacity;
        cap_d2 <= cap_d1;
        for (int i = 0; i < NUM_REQ; i++) begin
            valid_d[i] <= req_s1[i].u.valid;
        end
    end

    function automatic logic within_capacity(input grant_t g, input cap_t c);
        int n;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            n = 0;
            for (int i = 0; i < NUM_REQ; i++) begin
                if (g[i] == ch_t'(ch)) begin
                    n++;
                end
            end
            if (n > int'(c[ch])) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic logic invalid_ungranted(input grant_t g, input logic [NUM_REQ-1:0] v);
        for (int i = 0; i < NUM_REQ; i++) begin
            if (!v[i] && g[i] != NO_GRANT) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    a_reset_idle: assert property (@(posedge clk) disable iff (reset)
        !seen_in |-> (!out_valid && grant_channel == {NUM_REQ{NO_GRANT}}))
        else $error("outputs left their reset state before any input strobe");

    a_latency: assert property (@(posedge clk) disable iff (reset)
        in_valid |-> ##2 out_valid)
        else $error("out_valid missing two cycles after in_valid");

    a_no_spurious: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> $past(in_valid, 2))
        else $error("out_valid without in_valid two cycles earlier");

    a_capacity: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> within_capacity(grant_channel, cap_d2))
        else $error("a channel received more grants than its capacity");

    a_invalid_req: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> invalid_ungranted(grant_channel, valid_d))
        else $error("an invalid request received a grant");

endmodule

bind mpca mpca_sva sva0 (
    .clk              (clk),
    .reset            (reset),
    .in_valid         (in_valid),
    .channel_capacity (channel_capacity),
    .out_valid        (out_valid),
    .grant_channel    (grant_channel),
    .req_s1           (req_s1)
);

`default_nettype wire

//--- tests/mpca_tb.sv
`default_nettype none

module mpca_tb;

    import mpca_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int NUM_PRIO   = 8;
    localparam int NUM_EXH    = 3;
    localparam int NUM_RAND   = 200;
    localparam int NUM_TESTS  = NUM_PRIO + NUM_EXH + NUM_RAND;
    // a test takes at most two cycles, plus reset and drain
    localparam int WATCHDOG_TIME = (NUM_TESTS + 10) * 2 * CLK_PERIOD;

    typedef word_t [ROUNDS-1:0] round_keys_t;
    typedef block_t [NUM_BLK-1:0] packets_t;

    logic     clk;
    logic     reset;
    logic     in_valid;
    packets_t packets;
    key_t     key;
    cap_t     channel_capacity;
    logic     out_valid;
    grant_t   grant_channel;

    integer   seed;
    int       checked = 0;
    grant_t   exp_q[$];
    string    name_q[$];
    grant_t   exp_head;
    string    name_head;

    mpca dut0 (
        .clk              (clk),
        .reset            (reset),
        .in_valid         (in_valid),
        .packets          (packets),
        .key              (key),
        .channel_capacity (channel_capacity),
        .out_valid        (out_valid),
        .grant_channel    (grant_channel)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired before all results came back");
        $display("Simulation failed");
        $fatal(1);
    end

    // ==================================================================
    // cipher and reference model
    // ==================================================================

    function automatic word_t rot_right(input word_t v, input int n);
        return (v >> n) | (v << (16 - n));
    endfunction

    function automatic word_t rot_left(input word_t v, input int n);
        return (v << n) | (v >> (16 - n));
    endfunction

    function automatic round_keys_t round_keys(input key_t k);
        round_keys_t ks;
        ks[0] = k[15:0];
        for (int j = 1; j < ROUNDS; j++) begin
            ks[j] = (rot_right(ks[j-1], 7) + k[16*j +: 16]) ^ word_t'(j - 1);
        end
        return ks;
    endfunction

    // undoes the decrypt rounds, so k0 goes first
    function automatic block_t encrypt_block(input block_t plain, input round_keys_t ks);
        block_t b;
        word_t  x_old;
        b = plain;
        for (int j = 0; j < ROUNDS; j++) begin
            x_old = (rot_right(b.x, 9) + b.y) ^ ks[j];
            b.y   = rot_left(b.y, 2) ^ x_old;
            b.x   = x_old;
        end
        return b;
    endfunction

    function automatic int field_value(input int raw, input int width, input logic sgn);
        if (sgn && raw >= (1 << (width - 1))) begin
            return raw - (1 << width);
        end
        return raw;
    endfunction

    function automatic int score_of(input req_t r);
        int s;
        s = 4 * field_value(int'(r.u.qos), 2, r.u.mode)
          - 2 * field_value(int'(r.u.len), 4, r.u.mode)
          - 3 * field_value(int'(r.u.congestion), 2, r.u.mode)
          + field_value(int'(r.u.src_hint), 3, r.u.mode) + 7;
        // wrap to 6 bits signed
        s = s & 63;
        if (s >= 32) begin
            s = s - 64;
        end
        return s;
    endfunction

    function automatic logic comes_before(input int a, input int b, input req_vec_t rq);
        int sa;
        int sb;
        sa = score_of(rq[a]);
        sb = score_of(rq[b]);
        if (rq[a].u.valid != rq[b].u.valid) begin
            return rq[a].u.valid;
        end
        if (sa != sb) begin
            return sa > sb;
        end
        return a < b;
    endfunction

    function automatic grant_t expected_grants(input req_vec_t rq, input cap_t c);
        int     order[NUM_REQ];
        int     caps[NUM_CH];
        int     pos;
        int     idx;
        int     pref;
        int     pick;
        int     pivot;
        grant_t g;
        // rank position is the count of requests ahead
        for (int i = 0; i < NUM_REQ; i++) begin
            pos = 0;
            for (int j = 0; j < NUM_REQ; j++) begin
                if (j != i && comes_before(j, i, rq)) begin
                    pos++;
                end
            end
            order[pos] = i;
        end
        for (int ch = 0; ch < NUM_CH; ch++) begin
            caps[ch] = int'(c[ch]);
        end
        g     = {NUM_REQ{NO_GRANT}};
        pivot = int'(rq[order[0]].u.prefer);
        if (pivot == 3) begin
            pivot = 0;
        end
        for (int k = 0; k < NUM_REQ; k++) begin
            idx  = order[k];
            pref = int'(rq[idx].u.prefer);
            pick = 3;
            if (rq[idx].u.valid) begin
                if (pref < NUM_CH && caps[pref] > 0) begin
                    pick = pref;
                end else begin
                    for (int t = 0; t < NUM_CH; t++) begin
                        if (pick == 3 && caps[(pivot + t) % NUM_CH] > 0) begin
                            pick = (pivot + t) % NUM_CH;
                        end
                    end
                end
            end
            if (pick != 3) begin
                caps[pick] = caps[pick] - 1;
                g[idx]     = ch_t'(pick);
                pivot      = (pivot + 1) % NUM_CH;
            end else begin
                pivot = (pivot + 2) % NUM_CH;
            end
        end
        return g;
    endfunction

    // ==================================================================
    // stimulus and checks
    // ==================================================================

    task automatic random_reqs(output req_vec_t rq);
        logic [31:0] rnd;
        for (int i = 0; i < NUM_REQ; i++) begin
            rnd   = $random(seed);
            rq[i] = rnd[15:0];
        end
    endtask

    task automatic send_item(input string name, input req_vec_t rq, input key_t k,
                             input cap_t c);
        round_keys_t ks;
        packets_t    pk;
        block_t      plain;
        ks = round_keys(k);
        for (int b = 0; b < NUM_BLK; b++) begin
            plain.y = rq[2*b+1];
            plain.x = rq[2*b];
            pk[b]   = encrypt_block(plain, ks);
        end
        @(posedge clk);
        in_valid         <= 1'b1;
        packets          <= pk;
        key              <= k;
        channel_capacity <= c;
        exp_q.push_back(expected_grants(rq, c));
        name_q.push_back(name);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic compare_grant(input string name, input grant_t exp, input grant_t got);
        assert (got == exp) else begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, got);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    always @(negedge clk) begin
        if (!reset && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("out_valid pulsed with no result pending");
                $display("Simulation failed");
                $fatal(1);
            end else begin
                exp_head  = exp_q.pop_front();
                name_head = name_q.pop_front();
                compare_grant(name_head, exp_head, grant_channel);
                checked++;
            end
        end
    end

    initial begin
        req_vec_t    rq;
        logic [31:0] rnd_a;
        logic [31:0] rnd_b;
        logic [31:0] rnd_c;
        seed             = 86;
        reset            <= 1'b1;
        in_valid         <= 1'b0;
        packets          <= '0;
        key              <= '0;
        channel_capacity <= '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        // quiet cycles, outputs must hold their reset state
        repeat (3) idle_cycle();

        // one unit on channel 0, all valid, mode alternates
        for (int n = 0; n < NUM_PRIO; n++) begin
            random_reqs(rq);
            for (int i = 0; i < NUM_REQ; i++) begin
                rq[i].u.valid = 1'b1;
                rq[i].u.mode  = n[0];
            end
            rnd_a = $random(seed);
            rnd_b = $random(seed);
            send_item($sformatf("priority %0d", n), rq, {rnd_a, rnd_b}, cap_t'(9'b000_000_001));
        end

        for (int n = 0; n < NUM_EXH; n++) begin
            random_reqs(rq);
            rnd_a = $random(seed);
            rnd_b = $random(seed);
            send_item($sformatf("exhaustion %0d", n), rq, {rnd_a, rnd_b}, '0);
        end
        idle_cycle();

        for (int n = 0; n < NUM_RAND; n++) begin
            random_reqs(rq);
            rnd_a = $random(seed);
            rnd_b = $random(seed);
            rnd_c = $random(seed);
            send_item($sformatf("random %0d", n), rq, {rnd_a, rnd_b}, rnd_c[8:0]);
            if (rnd_c[13:12] == 2'b00) begin
                idle_cycle();
            end
        end
        idle_cycle();

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        if (checked == NUM_TESTS) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("checked %0d results, expected %0d", checked, NUM_TESTS);
            $display("Simulation failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire
